// File: tb.f
+incdir+testbench
common/l2_cache_pkg.sv
common/l2_addr_pkg.sv
l2_cache/line_store.sv
l2_cache/l1_tag_directory.sv
l2_cache/response_builder.sv
hw/l2_subsystem.sv
testbench/l2_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the L2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module l2_tb -o l2_sim

output=$(./obj_dir/l2_sim)
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
	exit 0
fi
exit 1

// File: testbench/l2_model.svh
`ifndef L2_MODEL_SVH
`define L2_MODEL_SVH

// reference copy of the line memory and of the L1D tags
logic [LINE_W-1:0] model_mem [LINE_COUNT];
logic [TAG_W-1:0] model_tag [L1_WAYS][L1_SETS];
logic model_valid [L1_WAYS][L1_SETS];
logic [31:0] lfsr_state = 32'h6896d153;
int error_count = 0;
int check_count = 0;

// pending acks and responses in request order, keyed by the request cycle
int ack_cyc_q [$];
int exp_cyc_q [$];
logic [ID_W-1:0] exp_id_q [$];
cpi_op_e exp_op_q [$];
logic exp_upd_q [$];
logic [WAY_W-1:0] exp_way_q [$];
logic [LINE_W-1:0] exp_data_q [$];

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic logic [LINE_W-1:0] take_bits(input int n);
	logic [LINE_W-1:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v[i] = lfsr_bit();
	return v;
endfunction

function automatic void clear_model_tags();
	for (int w = 0; w < L1_WAYS; w++)
		for (int s = 0; s < L1_SETS; s++)
			model_valid[w][s] = 1'b0;
endfunction

// applies one request in order and queues the response it must produce
function automatic void model_request(input logic [ID_W-1:0] id, input pci_op_e op,
	input logic [WAY_W-1:0] way, input l2_line_addr_u addr,
	input logic [LINE_W-1:0] data, input logic [MASK_W-1:0] mask, input int req_cyc);
	int idx;
	int set;
	logic hit;
	logic [WAY_W-1:0] hit_way;
	logic [LINE_W-1:0] line;
	cpi_op_e rsp_op;
	logic [WAY_W-1:0] rsp_way;
	idx = int'(addr.flat) % LINE_COUNT;
	set = int'(addr.fields.set);
	hit = 1'b0;
	hit_way = '0;
	for (int w = 0; w < L1_WAYS && !hit; w++)
	begin
		if (model_valid[w][set] && model_tag[w][set] == addr.fields.tag)
		begin
			hit = 1'b1;
			hit_way = WAY_W'(w);
		end
	end
	line = '0;
	rsp_op = CPI_OP_LOAD;
	rsp_way = '0;
	if (op == PCI_OP_LOAD)
	begin
		line = model_mem[idx];
		rsp_way = way;
		if (id[ID_W-1 -: UNIT_W] == UNIT_L1D)
		begin
			model_tag[way][set] = addr.fields.tag;
			model_valid[way][set] = 1'b1;
		end
	end
	else if (op == PCI_OP_STORE)
	begin
		line = model_mem[idx];
		for (int b = 0; b < MASK_W; b++)
			if (mask[b])
				line[b*8 +: 8] = data[b*8 +: 8];
		model_mem[idx] = line;
		rsp_op = CPI_OP_STORE;
		rsp_way = hit_way;
	end
	ack_cyc_q.push_back(req_cyc);
	exp_cyc_q.push_back(req_cyc);
	exp_id_q.push_back(id);
	exp_op_q.push_back(rsp_op);
	exp_upd_q.push_back(op == PCI_OP_STORE && hit);
	exp_way_q.push_back(rsp_way);
	exp_data_q.push_back(line);
endfunction

task automatic report_fault(input string what);
	$display("Protocol failure: %s", what);
	error_count++;
endtask

task automatic value_error(input string name, input string got, input string exp);
	$display("** Error: %s = %s, expected %s", name, got, exp);
	error_count++;
endtask

task automatic check_line(input string name, input logic [LINE_W-1:0] got,
	input logic [LINE_W-1:0] exp);
	check_count++;
	if (got !== exp)
		value_error(name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_op(input string name, input cpi_op_e got, input cpi_op_e exp);
	check_count++;
	if (got !== exp)
		value_error(name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	check_count++;
	if (got !== exp)
		value_error(name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_way(input string name, input logic [WAY_W-1:0] got,
	input logic [WAY_W-1:0] exp);
	check_count++;
	if (got !== exp)
		value_error(name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_id(input string name, input logic [ID_W-1:0] got,
	input logic [ID_W-1:0] exp);
	check_count++;
	if (got !== exp)
		value_error(name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

`endif

// File: testbench/l2_tb.sv
`timescale 1ns/1ps
`default_nettype none

module l2_tb;

	import l2_cache_pkg::*;
	import l2_addr_pkg::*;

	localparam int LINE_COUNT = 256;
	localparam int TIMEOUT_CYCLES = 20;

	logic clk = 1'b0;
	logic rst_i;
	logic pci_valid_i;
	logic [ID_W-1:0] pci_id_i;
	pci_op_e pci_op_i;
	logic [WAY_W-1:0] pci_way_i;
	logic [LINE_ADDR_W-1:0] pci_address_i;
	logic [LINE_W-1:0] pci_data_i;
	logic [MASK_W-1:0] pci_mask_i;
	logic pci_ack_o;
	logic cpi_valid_o;
	logic [ID_W-1:0] cpi_id_o;
	cpi_op_e cpi_op_o;
	logic cpi_update_o;
	logic [WAY_W-1:0] cpi_way_o;
	logic [LINE_W-1:0] cpi_data_o;

	int cyc = 0;
	int tests_failed = 0;
	int errors_at_start = 0;
	l2_line_addr_u addr_list [8];

	`include "l2_model.svh"

	always #4 clk = ~clk;

	l2_subsystem #(
		.LINE_COUNT(LINE_COUNT)
	) u_dut (
		.clk(clk),
		.rst_i(rst_i),
		.pci_valid_i(pci_valid_i),
		.pci_id_i(pci_id_i),
		.pci_op_i(pci_op_i),
		.pci_way_i(pci_way_i),
		.pci_address_i(pci_address_i),
		.pci_data_i(pci_data_i),
		.pci_mask_i(pci_mask_i),
		.pci_ack_o(pci_ack_o),
		.cpi_valid_o(cpi_valid_o),
		.cpi_id_o(cpi_id_o),
		.cpi_op_o(cpi_op_o),
		.cpi_update_o(cpi_update_o),
		.cpi_way_o(cpi_way_o),
		.cpi_data_o(cpi_data_o)
	);

	// advance one cycle and check ack and response at the falling edge
	task automatic tick();
		@(negedge clk);
		cyc++;
		if (ack_cyc_q.size() > 0 && ack_cyc_q[0] + 1 == cyc)
		begin
			ack_cyc_q.delete(0);
			if (pci_ack_o !== 1'b1)
				report_fault("no ack one cycle after a request");
		end
		else if (pci_ack_o !== 1'b0)
			report_fault("ack without a request one cycle before");
		if (exp_cyc_q.size() > 0 && exp_cyc_q[0] + 2 == cyc)
		begin
			exp_cyc_q.delete(0);
			if (cpi_valid_o !== 1'b1)
				report_fault("no response two cycles after a request");
			check_id("cpi_id_o", cpi_id_o, exp_id_q.pop_front());
			check_op("cpi_op_o", cpi_op_o, exp_op_q.pop_front());
			check_flag("cpi_update_o", cpi_update_o, exp_upd_q.pop_front());
			check_way("cpi_way_o", cpi_way_o, exp_way_q.pop_front());
			check_line("cpi_data_o", cpi_data_o, exp_data_q.pop_front());
		end
		else if (cpi_valid_o !== 1'b0)
			report_fault("response without a request two cycles before");
	endtask

	task automatic send(input logic [ID_W-1:0] id, input pci_op_e op,
		input logic [WAY_W-1:0] way, input l2_line_addr_u addr,
		input logic [LINE_W-1:0] data, input logic [MASK_W-1:0] mask);
		pci_valid_i = 1'b1;
		pci_id_i = id;
		pci_op_i = op;
		pci_way_i = way;
		pci_address_i = addr;
		pci_data_i = data;
		pci_mask_i = mask;
		model_request(id, op, way, addr, data, mask, cyc);
		tick();
	endtask

	task automatic send_random(input pci_op_e op, input l2_line_addr_u addr);
		logic [ID_W-1:0] id;
		logic [WAY_W-1:0] way;
		logic [LINE_W-1:0] data;
		logic [MASK_W-1:0] mask;
		id = ID_W'(take_bits(ID_W));
		way = WAY_W'(take_bits(WAY_W));
		data = take_bits(LINE_W);
		mask = MASK_W'(take_bits(MASK_W));
		send(id, op, way, addr, data, mask);
	endtask

	function automatic void discard_expected();
		ack_cyc_q.delete();
		exp_cyc_q.delete();
		exp_id_q.delete();
		exp_op_q.delete();
		exp_upd_q.delete();
		exp_way_q.delete();
		exp_data_q.delete();
	endfunction

	// wait for all outstanding responses, then one more cycle for stray ones
	task automatic drain();
		int waited;
		waited = 0;
		pci_valid_i = 1'b0;
		while (exp_cyc_q.size() > 0 && waited < TIMEOUT_CYCLES)
		begin
			tick();
			waited++;
		end
		if (exp_cyc_q.size() > 0)
		begin
			report_fault("responses still missing after 20 cycles");
			discard_expected();
		end
		tick();
	endtask

	task automatic reset_pulse();
		rst_i = 1'b1;
		tick();
		tick();
		rst_i = 1'b0;
		clear_model_tags();
	endtask

	// reset lands on a store hit still in flight while the store stays on the bus
	task automatic reset_busy();
		rst_i = 1'b1;
		discard_expected();
		for (int i = 0; i < 2; i++)
		begin
			@(negedge clk);
			cyc++;
			check_flag("pci_ack_o", pci_ack_o, 1'b0);
			check_flag("cpi_valid_o", cpi_valid_o, 1'b0);
			check_flag("cpi_update_o", cpi_update_o, 1'b0);
		end
		rst_i = 1'b0;
		clear_model_tags();
	endtask

	function automatic l2_line_addr_u make_addr(input int tag, input int set);
		l2_line_addr_u a;
		a.fields.tag = TAG_W'(tag);
		a.fields.set = SET_W'(set);
		return a;
	endfunction

	// 16 tags over 4 sets
	function automatic l2_line_addr_u rand_addr();
		logic [3:0] tag;
		logic [1:0] set;
		tag = 4'(take_bits(4));
		set = 2'(take_bits(2));
		return make_addr(int'(tag), int'(set));
	endfunction

	task automatic end_test(input string name);
		if (error_count == errors_at_start)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: %0d errors", name, error_count - errors_at_start);
			tests_failed++;
		end
		errors_at_start = error_count;
	endtask

	initial
	begin
		l2_line_addr_u a;
		rst_i = 1'b1;
		pci_valid_i = 1'b0;
		pci_id_i = '0;
		pci_op_i = PCI_OP_LOAD;
		pci_way_i = '0;
		pci_address_i = '0;
		pci_data_i = '0;
		pci_mask_i = '0;
		foreach (model_mem[i])
			model_mem[i] = '0;
		reset_pulse();

		// the L1D takes a line into way 2 and a store that hits it meets a reset
		send({UNIT_L1D, 2'd0}, PCI_OP_LOAD, 2'd2, make_addr(6, 1), '0, '0);
		send_random(PCI_OP_STORE, make_addr(6, 1));
		reset_busy();
		send(4'h2, PCI_OP_LOAD, 2'd1, make_addr(9, 3), '0, '0);
		send_random(PCI_OP_STORE, make_addr(6, 1));
		drain();
		end_test("reset and first load");

		for (int i = 0; i < 8; i++)
		begin
			addr_list[i] = rand_addr();
			send_random(PCI_OP_STORE, addr_list[i]);
			drain();
		end
		for (int i = 0; i < 8; i++)
		begin
			send_random(PCI_OP_LOAD, addr_list[i]);
			drain();
		end
		end_test("masked stores then loads");

		for (int i = 0; i < 16; i++)
		begin
			a = rand_addr();
			send_random(PCI_OP_STORE, a);
			send_random(PCI_OP_LOAD, a);
			send_random(pci_op_e'(2'(take_bits(2))), rand_addr());
		end
		drain();
		end_test("back to back");

		// fresh directory where the L1D fills ways 0 to 3 of set 2 and unit 2 loads set 1
		reset_pulse();
		for (int w = 0; w < L1_WAYS; w++)
		begin
			addr_list[w] = make_addr(w + 4, 2);
			send({UNIT_L1D, 2'(w)}, PCI_OP_LOAD, 2'(w), addr_list[w], '0, '0);
			addr_list[w + 4] = make_addr(w + 8, 1);
			send({2'd2, 2'(w)}, PCI_OP_LOAD, 2'(w), addr_list[w + 4], '0, '0);
		end
		for (int i = 0; i < 8; i++)
			send_random(PCI_OP_STORE, addr_list[i]);
		send_random(PCI_OP_STORE, make_addr(15, 0));
		drain();
		end_test("directory update");

		send_random(PCI_OP_FLUSH, addr_list[0]);
		send_random(PCI_OP_INVALIDATE, addr_list[1]);
		send_random(PCI_OP_FLUSH, addr_list[4]);
		drain();
		send(4'h0, PCI_OP_LOAD, 2'd3, addr_list[0], '0, '0);
		send(4'h0, PCI_OP_LOAD, 2'd3, addr_list[1], '0, '0);
		send_random(PCI_OP_STORE, addr_list[1]);
		send_random(PCI_OP_STORE, addr_list[4]);
		drain();
		end_test("flush and invalidate");

		for (int i = 0; i < 2000; i++)
		begin
			if (2'(take_bits(2)) == 2'd0)
			begin
				pci_valid_i = 1'b0;
				tick();
			end
			send_random(pci_op_e'(2'(take_bits(2))), rand_addr());
		end
		drain();
		end_test("random mix");

		$display("tests: 6 run, %0d failed, %0d checks, %0d errors",
			tests_failed, check_count, error_count);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/l2_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module l2_subsystem
#(
	parameter int LINE_COUNT = 256
)
(
	input wire logic clk,
	input wire logic rst_i,
	input wire logic pci_valid_i,
	input wire logic [l2_cache_pkg::ID_W-1:0] pci_id_i,
	input wire l2_cache_pkg::pci_op_e pci_op_i,
	input wire logic [l2_addr_pkg::WAY_W-1:0] pci_way_i,
	input wire logic [l2_cache_pkg::LINE_ADDR_W-1:0] pci_address_i,
	input wire logic [l2_cache_pkg::LINE_W-1:0] pci_data_i,
	input wire logic [l2_cache_pkg::MASK_W-1:0] pci_mask_i,
	output logic pci_ack_o,
	output logic cpi_valid_o,
	output logic [l2_cache_pkg::ID_W-1:0] cpi_id_o,
	output l2_cache_pkg::cpi_op_e cpi_op_o,
	output logic cpi_update_o,
	output logic [l2_addr_pkg::WAY_W-1:0] cpi_way_o,
	output logic [l2_cache_pkg::LINE_W-1:0] cpi_data_o
);

	import l2_cache_pkg::*;
	import l2_addr_pkg::*;

	l2_line_addr_u req_addr;
	logic [LINE_W-1:0] line_data;
	logic l1_hit;
	logic [WAY_W-1:0] l1_hit_way;

	assign req_addr = pci_address_i;

	line_store #(
		.LINE_COUNT(LINE_COUNT)
	) u_line_store (
		.clk(clk),
		.req_valid_i(pci_valid_i),
		.req_op_i(pci_op_i),
		.line_addr_i(req_addr),
		.store_data_i(pci_data_i),
		.store_mask_i(pci_mask_i),
		.line_data_o(line_data)
	);

	l1_tag_directory u_tag_dir (
		.clk(clk),
		.rst_i(rst_i),
		.req_valid_i(pci_valid_i),
		.req_op_i(pci_op_i),
		.req_id_i(pci_id_i),
		.req_way_i(pci_way_i),
		.line_addr_i(req_addr),
		.l1_hit_o(l1_hit),
		.l1_hit_way_o(l1_hit_way)
	);

	response_builder u_resp (
		.clk(clk),
		.rst_i(rst_i),
		.req_valid_i(pci_valid_i),
		.req_id_i(pci_id_i),
		.req_op_i(pci_op_i),
		.req_way_i(pci_way_i),
		.line_data_i(line_data),
		.l1_hit_i(l1_hit),
		.l1_hit_way_i(l1_hit_way),
		.pci_ack_o(pci_ack_o),
		.cpi_valid_o(cpi_valid_o),
		.cpi_id_o(cpi_id_o),
		.cpi_op_o(cpi_op_o),
		.cpi_update_o(cpi_update_o),
		.cpi_way_o(cpi_way_o),
		.cpi_data_o(cpi_data_o)
	);

endmodule

`default_nettype wire

// File: l2_cache/response_builder.sv
`timescale 1ns/1ps
`default_nettype none

module response_builder
(
	input wire logic clk,
	input wire logic rst_i,
	input wire logic req_valid_i,
	input wire logic [l2_cache_pkg::ID_W-1:0] req_id_i,
	input wire l2_cache_pkg::pci_op_e req_op_i,
	input wire logic [l2_addr_pkg::WAY_W-1:0] req_way_i,
	input wire logic [l2_cache_pkg::LINE_W-1:0] line_data_i,
	input wire logic l1_hit_i,
	input wire logic [l2_addr_pkg::WAY_W-1:0] l1_hit_way_i,
	output logic pci_ack_o,
	output logic cpi_valid_o,
	output logic [l2_cache_pkg::ID_W-1:0] cpi_id_o,
	output l2_cache_pkg::cpi_op_e cpi_op_o,
	output logic cpi_update_o,
	output logic [l2_addr_pkg::WAY_W-1:0] cpi_way_o,
	output logic [l2_cache_pkg::LINE_W-1:0] cpi_data_o
);

	import l2_cache_pkg::*;
	import l2_addr_pkg::*;

	logic s1_valid;
	logic [ID_W-1:0] s1_id;
	pci_op_e s1_op;
	logic [WAY_W-1:0] s1_way;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			pci_ack_o <= 1'b0;
			s1_valid <= 1'b0;
			cpi_valid_o <= 1'b0;
			cpi_update_o <= 1'b0;
		end
		else
		begin
			pci_ack_o <= req_valid_i;
			s1_valid <= req_valid_i;
			cpi_valid_o <= s1_valid;
			// the L1D only patches its copy when it holds the line
			cpi_update_o <= s1_valid && s1_op == PCI_OP_STORE && l1_hit_i;
		end
	end

	// stage 1 request fields
	always_ff @(posedge clk)
	begin
		s1_id <= req_id_i;
		s1_op <= req_op_i;
		s1_way <= req_way_i;
	end

	// stage 2, line data and hit arrive from the other blocks this cycle
	always_ff @(posedge clk)
	begin
		cpi_id_o <= s1_id;
		cpi_data_o <= line_data_i;
		case (s1_op)
			PCI_OP_LOAD:
			begin
				cpi_op_o <= CPI_OP_LOAD;
				cpi_way_o <= s1_way;
			end
			PCI_OP_STORE:
			begin
				cpi_op_o <= CPI_OP_STORE;
				cpi_way_o <= l1_hit_way_i;
			end
			default:
			begin
				// flush and invalidate are answered like a load
				cpi_op_o <= CPI_OP_LOAD;
				cpi_way_o <= '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: l2_cache/l1_tag_directory.sv
`timescale 1ns/1ps
`default_nettype none

module l1_tag_directory
(
	input wire logic clk,
	input wire logic rst_i,
	input wire logic req_valid_i,
	input wire l2_cache_pkg::pci_op_e req_op_i,
	input wire logic [l2_cache_pkg::ID_W-1:0] req_id_i,
	input wire logic [l2_addr_pkg::WAY_W-1:0] req_way_i,
	input wire l2_addr_pkg::l2_line_addr_u line_addr_i,
	output logic l1_hit_o,
	output logic [l2_addr_pkg::WAY_W-1:0] l1_hit_way_o
);

	import l2_cache_pkg::*;
	import l2_addr_pkg::*;

	// shadow of the L1D tag memory
	logic [TAG_W-1:0] tag_mem [L1_WAYS][L1_SETS];
	logic [L1_SETS-1:0] valid_bits [L1_WAYS];

	logic [TAG_W-1:0] req_tag;
	logic [SET_W-1:0] req_set;
	logic [UNIT_W-1:0] req_unit;
	logic [L1_WAYS-1:0] way_match;
	logic [WAY_W-1:0] match_way;
	logic fill;

	assign req_tag = line_addr_i.fields.tag;
	assign req_set = line_addr_i.fields.set;
	assign req_unit = req_id_i[ID_W-1 -: UNIT_W];

	// the L1D gets the line it loads, in the way it asked for
	assign fill = req_valid_i && req_op_i == PCI_OP_LOAD && req_unit == UNIT_L1D;

	// compare against the tags as they stand before this edge
	always_comb
	begin
		for (int w = 0; w < L1_WAYS; w++)
		begin
			way_match[w] = valid_bits[w][req_set] && tag_mem[w][req_set] == req_tag;
		end
	end

	// lowest matching way wins if a line sits in two ways
	always_comb
	begin
		match_way = '0;
		for (int w = L1_WAYS - 1; w >= 0; w--)
		begin
			if (way_match[w])
				match_way = WAY_W'(w);
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill)
			tag_mem[req_way_i][req_set] <= req_tag;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int w = 0; w < L1_WAYS; w++)
			begin
				valid_bits[w] <= '0;
			end
		end
		else if (fill)
		begin
			valid_bits[req_way_i][req_set] <= 1'b1;
		end
	end

	// stage 1 lookup result
	always_ff @(posedge clk)
	begin
		if (rst_i)
			l1_hit_o <= 1'b0;
		else
			l1_hit_o <= req_valid_i && |way_match;
	end

	always_ff @(posedge clk)
	begin
		l1_hit_way_o <= match_way;
	end

endmodule

`default_nettype wire

// File: l2_cache/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store
#(
	parameter int LINE_COUNT = 256
)
(
	input wire logic clk,
	input wire logic req_valid_i,
	input wire l2_cache_pkg::pci_op_e req_op_i,
	input wire l2_addr_pkg::l2_line_addr_u line_addr_i,
	input wire logic [l2_cache_pkg::LINE_W-1:0] store_data_i,
	input wire logic [l2_cache_pkg::MASK_W-1:0] store_mask_i,
	output logic [l2_cache_pkg::LINE_W-1:0] line_data_o
);

	import l2_cache_pkg::*;

	localparam int INDEX_W = $clog2(LINE_COUNT);

	logic [LINE_W-1:0] mem [LINE_COUNT];
	logic [INDEX_W-1:0] index;
	logic [LINE_W-1:0] old_line;
	logic [LINE_W-1:0] merged_line;
	logic store_en;

	// zeroed at start so unwritten lines read back as zero
	initial
	begin
		for (int i = 0; i < LINE_COUNT; i++)
		begin
			mem[i] = '0;
		end
	end

	// only the low bits of the line address select a line
	assign index = line_addr_i.flat[INDEX_W-1:0];
	assign old_line = mem[index];
	assign store_en = req_valid_i && req_op_i == PCI_OP_STORE;

	// byte merge of the store data into the old line
	always_comb
	begin
		for (int b = 0; b < MASK_W; b++)
		begin
			if (store_mask_i[b])
				merged_line[b*8 +: 8] = store_data_i[b*8 +: 8];
			else
				merged_line[b*8 +: 8] = old_line[b*8 +: 8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (store_en)
			mem[index] <= merged_line;
	end

	// stage 1 data, a store returns the line as written
	always_ff @(posedge clk)
	begin
		if (!req_valid_i)
		begin
			line_data_o <= '0;
		end
		else
		begin
			case (req_op_i)
				PCI_OP_LOAD:
					line_data_o <= old_line;
				PCI_OP_STORE:
					line_data_o <= merged_line;
				default:
					line_data_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: common/l2_addr_pkg.sv
`default_nettype none

package l2_addr_pkg;

	// L1D geometry, 4 ways of 32 sets
	localparam int SET_W = 5;
	localparam int TAG_W = 21;
	localparam int L1_SETS = 2 ** SET_W;
	localparam int L1_WAYS = 4;
	localparam int WAY_W = 2;

	typedef struct packed
	{
		logic [TAG_W-1:0] tag;
		logic [SET_W-1:0] set;
	} l2_tag_set_t;

	// same 26 bits, either a flat line index or the L1D tag and set
	typedef union packed
	{
		logic [TAG_W+SET_W-1:0] flat;
		l2_tag_set_t fields;
	} l2_line_addr_u;

endpackage

`default_nettype wire

// File: common/l2_cache_pkg.sv
`default_nettype none

package l2_cache_pkg;

	// one cache line is 64 bytes
	localparam int LINE_W = 512;

	// byte enables for a store, one per byte of the line
	localparam int MASK_W = LINE_W / 8;

	// line address, the byte offset within the line is already dropped
	localparam int LINE_ADDR_W = 26;

	// request id is {unit, thread}
	localparam int ID_W = 4;
	localparam int UNIT_W = 2;

	// unit number of the L1 data cache
	localparam logic [UNIT_W-1:0] UNIT_L1D = 2'd1;

	// request ops from the L1 side
	typedef enum logic [1:0]
	{
		PCI_OP_LOAD = 2'd0,
		PCI_OP_STORE = 2'd1,
		PCI_OP_FLUSH = 2'd2,
		PCI_OP_INVALIDATE = 2'd3
	} pci_op_e;

	// response ops back to the L1 side
	// write-validate is reserved and never sent by this cache
	typedef enum logic [1:0]
	{
		CPI_OP_LOAD = 2'd0,
		CPI_OP_STORE = 2'd1,
		CPI_OP_WRITE_VALIDATE = 2'd2
	} cpi_op_e;

endpackage

`default_nettype wire
